/* Makefile */
VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard rtl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/bus_router.sv */
`include "soc_defs.svh"

module bus_router
  import soc_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       mem_valid_i,
  input  word_t                      mem_addr_i,
  input  word_t                      mem_wdata_i,
  input  logic [3:0]                 mem_wstrb_i,
  input  word_t                      ram_rdata_i,
  input  logic                       mmio_ready_i,
  input  word_t                      mmio_rdata_i,
  output logic                       mem_ready_o,
  output word_t                      mem_rdata_o,
  output logic [3:0]                 ram_wstrb_o,
  output logic [`SOC_RAM_AW-1:0]     ram_addr_o,
  output word_t                      ram_wdata_o,
  output logic                       mmio_req_o,
  output logic [`SOC_MMIO_OFS_W-1:0] mmio_offset_o,
  output word_t                      mmio_wdata_o,
  output logic [3:0]                 mmio_wstrb_o
);

  localparam word_t RAM_BYTES = word_t'(`SOC_RAM_WORDS * 4);

  bus_region_e region;
  logic        ram_sel;
  logic        ram_ready_q;

  // decode stage
  always_comb begin
    if (mem_addr_i < RAM_BYTES) begin
      region = REGION_RAM;
    end else if (mem_addr_i[31:`SOC_MMIO_OFS_W] == `SOC_MMIO_PAGE) begin
      region = REGION_MMIO;
    end else begin
      region = REGION_NONE;
    end
  end

  // strobes only while the access is still pending
  assign ram_sel     = mem_valid_i && !mem_ready_o && (region == REGION_RAM);
  assign ram_wstrb_o = ram_sel ? mem_wstrb_i : 4'h0;
  assign ram_addr_o  = mem_addr_i[`SOC_RAM_AW+1:2];
  assign ram_wdata_o = mem_wdata_i;

  assign mmio_req_o    = mem_valid_i && (region == REGION_MMIO);
  assign mmio_offset_o = mem_addr_i[`SOC_MMIO_OFS_W-1:0];
  assign mmio_wdata_o  = mem_wdata_i;
  assign mmio_wstrb_o  = mem_wstrb_i;

  // sram answers one cycle later
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ram_ready_q <= 1'b0;
    end else begin
      ram_ready_q <= ram_sel;
    end
  end

  assign mem_ready_o = ram_ready_q || mmio_ready_i;

  always_comb begin
    if (ram_ready_q) begin
      mem_rdata_o = ram_rdata_i;
    end else if (mmio_ready_i) begin
      mem_rdata_o = mmio_rdata_i;
    end else begin
      mem_rdata_o = '0;
    end
  end

endmodule

/* rtl/gpio_pad_ctrl.sv */
`include "soc_defs.svh"

module gpio_pad_ctrl
  import soc_pkg::*;
(
  input  logic       rst_n_i,
  input  logic       clk_i,
  input  logic       xtal_in_i,
  input  logic       clk_pll_i,
  input  logic       trap_i,
  input  gpio_t      gpio_i,
  input  gpio_t      gpio_oeb_i,
  input  gpio_t      gpio_pu_i,
  input  gpio_t      gpio_pd_i,
  input  route_sel_t xtal_dest_i,
  input  route_sel_t pll_dest_i,
  input  route_sel_t trap_dest_i,
  output gpio_t      gpio_out_o,
  output gpio_t      gpio_outenb_o,
  output gpio_t      gpio_pullupb_o,
  output gpio_t      gpio_pulldownb_o
);

  // pads 5-7, 8-10 and 11-13
  localparam gpio_t XTAL_GRP = 16'h00e0;
  localparam gpio_t PLL_GRP  = 16'h0700;
  localparam gpio_t TRAP_GRP = 16'h3800;

  gpio_t grp_on;
  gpio_t pad_out;

  assign grp_on = ({`SOC_GPIO_W{xtal_dest_i != '0}} & XTAL_GRP) |
                  ({`SOC_GPIO_W{pll_dest_i != '0}} & PLL_GRP) |
                  ({`SOC_GPIO_W{trap_dest_i != '0}} & TRAP_GRP);

  always_comb begin
    pad_out = gpio_i;
    case (xtal_dest_i)
      2'd1:    pad_out[5] = xtal_in_i;
      2'd2:    pad_out[6] = xtal_in_i;
      2'd3:    pad_out[7] = xtal_in_i;
      default: ;
    endcase
    // pad 10 stays on its register
    case (pll_dest_i)
      2'd1:    pad_out[8] = clk_pll_i;
      2'd2:    pad_out[9] = clk_i;
      default: ;
    endcase
    case (trap_dest_i)
      2'd1:    pad_out[11] = trap_i;
      2'd2:    pad_out[12] = trap_i;
      2'd3:    pad_out[13] = trap_i;
      default: ;
    endcase
  end

  assign gpio_out_o       = pad_out;
  // all pads tristated while reset is asserted
  assign gpio_outenb_o    = {`SOC_GPIO_W{!rst_n_i}} | (gpio_oeb_i & ~grp_on);
  assign gpio_pullupb_o   = gpio_pu_i | grp_on;
  assign gpio_pulldownb_o = gpio_pd_i | grp_on;

endmodule

/* rtl/irq_vector.sv */
`include "soc_defs.svh"

module irq_vector
  import soc_pkg::*;
(
  input  gpio_t      gpio_in_i,
  input  route_sel_t irq7_src_i,
  input  route_sel_t irq8_src_i,
  input  logic       irq_pin_i,
  input  logic       irq_spi_i,
  output word_t      irq_o
);

  // code n picks src[n-1], code 0 is no source
  function automatic logic pick_src(route_sel_t sel, logic [2:0] src);
    logic bit_v;
    case (sel)
      2'd1:    bit_v = src[0];
      2'd2:    bit_v = src[1];
      2'd3:    bit_v = src[2];
      default: bit_v = 1'b0;
    endcase
    return bit_v;
  endfunction

  always_comb begin
    irq_o                = '0;
    irq_o[`SOC_IRQ_PIN]  = irq_pin_i;
    irq_o[`SOC_IRQ_SPI]  = irq_spi_i;
    irq_o[`SOC_IRQ_SEL7] = pick_src(irq7_src_i, gpio_in_i[2:0]);
    irq_o[`SOC_IRQ_SEL8] = pick_src(irq8_src_i, gpio_in_i[5:3]);
  end

endmodule

/* rtl/mmio_regs.sv */
`include "soc_defs.svh"

module mmio_regs
  import soc_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       mmio_req_i,
  input  logic [`SOC_MMIO_OFS_W-1:0] mmio_offset_i,
  input  word_t                      mmio_wdata_i,
  input  logic [3:0]                 mmio_wstrb_i,
  input  gpio_t                      gpio_in_i,
  input  gpio_t                      gpio_out_i,
  input  logic [`SOC_CFG_W-1:0]      spi_cfg_i,
  input  logic [`SOC_MFGR_W-1:0]     mfgr_id_i,
  input  logic [`SOC_PROD_W-1:0]     prod_id_i,
  input  logic [`SOC_MASK_W-1:0]     mask_rev_i,
  input  logic                       clk_ext_sel_i,
  output logic                       mmio_ready_o,
  output word_t                      mmio_rdata_o,
  output gpio_t                      gpio_o,
  output gpio_t                      gpio_oeb_o,
  output gpio_t                      gpio_pu_o,
  output gpio_t                      gpio_pd_o,
  output route_sel_t                 xtal_dest_o,
  output route_sel_t                 pll_dest_o,
  output route_sel_t                 trap_dest_o,
  output route_sel_t                 irq7_src_o,
  output route_sel_t                 irq8_src_o
);

  logic       ready_q;
  logic       serve;
  word_t      rd_word;
  word_t      rdata_q;
  gpio_t      gpio_q;
  gpio_t      oeb_q;
  gpio_t      pu_q;
  gpio_t      pd_q;
  route_sel_t xtal_q;
  route_sel_t pll_q;
  route_sel_t trap_q;
  route_sel_t irq7_q;
  route_sel_t irq8_q;

  // low byte under strobe 0, high byte under strobe 1
  function automatic gpio_t merge_half(gpio_t cur, word_t wdata, logic [3:0] wstrb);
    gpio_t nxt;
    nxt = cur;
    if (wstrb[0]) begin
      nxt[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      nxt[15:8] = wdata[15:8];
    end
    return nxt;
  endfunction

  // one cycle per request, ready drops after serving
  assign serve = mmio_req_i && !ready_q;

  always_comb begin
    case (mmio_offset_i)
      `SOC_REG_GPIO:      rd_word = {gpio_out_i, gpio_in_i};
      `SOC_REG_OEB:       rd_word = word_t'(oeb_q);
      `SOC_REG_PU:        rd_word = word_t'(pu_q);
      `SOC_REG_PD:        rd_word = word_t'(pd_q);
      `SOC_REG_CFG:       rd_word = word_t'(spi_cfg_i);
      `SOC_REG_MFGR:      rd_word = word_t'(mfgr_id_i);
      `SOC_REG_PROD:      rd_word = word_t'(prod_id_i);
      `SOC_REG_MASK:      rd_word = word_t'(mask_rev_i);
      `SOC_REG_CLKSEL:    rd_word = word_t'(clk_ext_sel_i);
      `SOC_REG_XTAL_DEST: rd_word = word_t'(xtal_q);
      `SOC_REG_PLL_DEST:  rd_word = word_t'(pll_q);
      `SOC_REG_TRAP_DEST: rd_word = word_t'(trap_q);
      `SOC_REG_IRQ7_SRC:  rd_word = word_t'(irq7_q);
      `SOC_REG_IRQ8_SRC:  rd_word = word_t'(irq8_q);
      // unmapped offsets read as zero
      default:            rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      gpio_q  <= '0;
      oeb_q   <= `SOC_OEB_RST;
      pu_q    <= '0;
      pd_q    <= '0;
      xtal_q  <= '0;
      pll_q   <= '0;
      trap_q  <= '0;
      irq7_q  <= '0;
      irq8_q  <= '0;
    end else begin
      ready_q <= serve;
      if (serve) begin
        case (mmio_offset_i)
          `SOC_REG_GPIO: gpio_q <= merge_half(gpio_q, mmio_wdata_i, mmio_wstrb_i);
          `SOC_REG_OEB:  oeb_q  <= merge_half(oeb_q, mmio_wdata_i, mmio_wstrb_i);
          `SOC_REG_PU:   pu_q   <= merge_half(pu_q, mmio_wdata_i, mmio_wstrb_i);
          `SOC_REG_PD:   pd_q   <= merge_half(pd_q, mmio_wdata_i, mmio_wstrb_i);
          `SOC_REG_XTAL_DEST: begin
            if (mmio_wstrb_i[0]) xtal_q <= mmio_wdata_i[1:0];
          end
          `SOC_REG_PLL_DEST: begin
            if (mmio_wstrb_i[0]) pll_q <= mmio_wdata_i[1:0];
          end
          `SOC_REG_TRAP_DEST: begin
            if (mmio_wstrb_i[0]) trap_q <= mmio_wdata_i[1:0];
          end
          `SOC_REG_IRQ7_SRC: begin
            if (mmio_wstrb_i[0]) irq7_q <= mmio_wdata_i[1:0];
          end
          `SOC_REG_IRQ8_SRC: begin
            if (mmio_wstrb_i[0]) irq8_q <= mmio_wdata_i[1:0];
          end
          default: ;
        endcase
      end
    end
  end

  // read data captured with the pre-write values
  always_ff @(posedge clk_i) begin
    if (serve) begin
      rdata_q <= rd_word;
    end
  end

  assign mmio_ready_o = ready_q;
  assign mmio_rdata_o = rdata_q;
  assign gpio_o       = gpio_q;
  assign gpio_oeb_o   = oeb_q;
  assign gpio_pu_o    = pu_q;
  assign gpio_pd_o    = pd_q;
  assign xtal_dest_o  = xtal_q;
  assign pll_dest_o   = pll_q;
  assign trap_dest_o  = trap_q;
  assign irq7_src_o   = irq7_q;
  assign irq8_src_o   = irq8_q;

endmodule

/* rtl/soc_bus_top.sv */
`include "soc_defs.svh"

module soc_bus_top
  import soc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   mem_valid_i,
  input  word_t                  mem_addr_i,
  input  word_t                  mem_wdata_i,
  input  logic [3:0]             mem_wstrb_i,
  input  word_t                  ram_rdata_i,
  input  gpio_t                  gpio_in_i,
  input  logic                   xtal_in_i,
  input  logic                   clk_pll_i,
  input  logic                   trap_i,
  input  logic                   irq_pin_i,
  input  logic                   irq_spi_i,
  input  logic [`SOC_CFG_W-1:0]  spi_cfg_i,
  input  logic [`SOC_MFGR_W-1:0] mfgr_id_i,
  input  logic [`SOC_PROD_W-1:0] prod_id_i,
  input  logic [`SOC_MASK_W-1:0] mask_rev_i,
  input  logic                   clk_ext_sel_i,
  output logic                   mem_ready_o,
  output word_t                  mem_rdata_o,
  output logic [3:0]             ram_wstrb_o,
  output logic [`SOC_RAM_AW-1:0] ram_addr_o,
  output word_t                  ram_wdata_o,
  output gpio_t                  gpio_out_o,
  output gpio_t                  gpio_outenb_o,
  output gpio_t                  gpio_pullupb_o,
  output gpio_t                  gpio_pulldownb_o,
  output word_t                  irq_o
);

  logic                       mmio_req;
  logic [`SOC_MMIO_OFS_W-1:0] mmio_offset;
  word_t                      mmio_wdata;
  logic [3:0]                 mmio_wstrb;
  logic                       mmio_ready;
  word_t                      mmio_rdata;
  gpio_t                      gpio_reg;
  gpio_t                      gpio_oeb;
  gpio_t                      gpio_pu;
  gpio_t                      gpio_pd;
  route_sel_t                 xtal_dest;
  route_sel_t                 pll_dest;
  route_sel_t                 trap_dest;
  route_sel_t                 irq7_src;
  route_sel_t                 irq8_src;

  bus_router u_bus_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mem_valid_i  (mem_valid_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_wstrb_i  (mem_wstrb_i),
    .ram_rdata_i  (ram_rdata_i),
    .mmio_ready_i (mmio_ready),
    .mmio_rdata_i (mmio_rdata),
    .mem_ready_o  (mem_ready_o),
    .mem_rdata_o  (mem_rdata_o),
    .ram_wstrb_o  (ram_wstrb_o),
    .ram_addr_o   (ram_addr_o),
    .ram_wdata_o  (ram_wdata_o),
    .mmio_req_o   (mmio_req),
    .mmio_offset_o(mmio_offset),
    .mmio_wdata_o (mmio_wdata),
    .mmio_wstrb_o (mmio_wstrb)
  );

  mmio_regs u_mmio_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mmio_req_i   (mmio_req),
    .mmio_offset_i(mmio_offset),
    .mmio_wdata_i (mmio_wdata),
    .mmio_wstrb_i (mmio_wstrb),
    .gpio_in_i    (gpio_in_i),
    .gpio_out_i   (gpio_out_o),
    .spi_cfg_i    (spi_cfg_i),
    .mfgr_id_i    (mfgr_id_i),
    .prod_id_i    (prod_id_i),
    .mask_rev_i   (mask_rev_i),
    .clk_ext_sel_i(clk_ext_sel_i),
    .mmio_ready_o (mmio_ready),
    .mmio_rdata_o (mmio_rdata),
    .gpio_o       (gpio_reg),
    .gpio_oeb_o   (gpio_oeb),
    .gpio_pu_o    (gpio_pu),
    .gpio_pd_o    (gpio_pd),
    .xtal_dest_o  (xtal_dest),
    .pll_dest_o   (pll_dest),
    .trap_dest_o  (trap_dest),
    .irq7_src_o   (irq7_src),
    .irq8_src_o   (irq8_src)
  );

  gpio_pad_ctrl u_gpio_pad_ctrl (
    .rst_n_i         (rst_n_i),
    .clk_i           (clk_i),
    .xtal_in_i       (xtal_in_i),
    .clk_pll_i       (clk_pll_i),
    .trap_i          (trap_i),
    .gpio_i          (gpio_reg),
    .gpio_oeb_i      (gpio_oeb),
    .gpio_pu_i       (gpio_pu),
    .gpio_pd_i       (gpio_pd),
    .xtal_dest_i     (xtal_dest),
    .pll_dest_i      (pll_dest),
    .trap_dest_i     (trap_dest),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o)
  );

  irq_vector u_irq_vector (
    .gpio_in_i (gpio_in_i),
    .irq7_src_i(irq7_src),
    .irq8_src_i(irq8_src),
    .irq_pin_i (irq_pin_i),
    .irq_spi_i (irq_spi_i),
    .irq_o     (irq_o)
  );

endmodule

/* rtl/soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// pads and on-chip sram
`define SOC_GPIO_W        16
`define SOC_RAM_WORDS     16384
`define SOC_RAM_AW        14

// register page, upper 24 address bits
`define SOC_MMIO_PAGE     24'h030000
`define SOC_MMIO_OFS_W    8

`define SOC_REG_GPIO      8'h00
`define SOC_REG_OEB       8'h04
`define SOC_REG_PU        8'h08
`define SOC_REG_PD        8'h0c
`define SOC_REG_CFG       8'h18
`define SOC_REG_MFGR      8'h24
`define SOC_REG_PROD      8'h28
`define SOC_REG_MASK      8'h2c
`define SOC_REG_CLKSEL    8'h30
`define SOC_REG_XTAL_DEST 8'h34
`define SOC_REG_PLL_DEST  8'h38
`define SOC_REG_TRAP_DEST 8'h3c
`define SOC_REG_IRQ7_SRC  8'h40
`define SOC_REG_IRQ8_SRC  8'h44

// housekeeping spi read-only field widths
`define SOC_CFG_W         8
`define SOC_MFGR_W        12
`define SOC_PROD_W        8
`define SOC_MASK_W        4

// pads come up as inputs
`define SOC_OEB_RST       16'hffff

// interrupt bit positions
`define SOC_IRQ_PIN       5
`define SOC_IRQ_SPI       6
`define SOC_IRQ_SEL7      7
`define SOC_IRQ_SEL8      8

`endif

/* rtl/soc_pkg.sv */
`include "soc_defs.svh"

package soc_pkg;

  // decoded target of a native bus request
  typedef enum logic [1:0] {
    REGION_NONE = 2'd0,
    REGION_RAM  = 2'd1,
    REGION_MMIO = 2'd2
  } bus_region_e;

  // one bit per pad
  typedef logic [`SOC_GPIO_W-1:0] gpio_t;

  // routing or irq source select, 0 is off
  typedef logic [1:0] route_sel_t;

  typedef logic [31:0] word_t;

endpackage

/* tb/soc_bus_properties.sv */
`include "soc_defs.svh"

module soc_bus_properties
  import soc_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       mem_valid_i,
  input word_t      mem_addr_i,
  input logic       mem_ready_i,
  input logic [3:0] ram_wstrb_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam word_t RAM_BYTES = word_t'(`SOC_RAM_WORDS * 4);

  // ready is a single-cycle pulse
  ready_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_ready_i |=> !mem_ready_i
  ) else $error("mem_ready_o high for two cycles in a row");

  ready_after_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_ready_i |-> $past(mem_valid_i)
  ) else $error("mem_ready_o without mem_valid_i in the cycle before");

  // no sram write outside its address range
  no_strobe_outside_ram: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (mem_addr_i >= RAM_BYTES) |-> (ram_wstrb_i == 4'h0)
  ) else $error("ram_wstrb_o active for an address outside the sram");

endmodule

bind soc_bus_top soc_bus_properties u_bus_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .mem_valid_i(mem_valid_i),
  .mem_addr_i (mem_addr_i),
  .mem_ready_i(mem_ready_o),
  .ram_wstrb_i(ram_wstrb_o)
);

/* tb/soc_bus_tb.sv */
`include "soc_defs.svh"

module soc_bus_tb
  import soc_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    SEED           = 32'h75eb_30a8;
  localparam int    TIMEOUT_CYCLES = 20;
  localparam gpio_t GPIO_VAL       = 16'h3ca5;
  localparam gpio_t OEB_VAL        = 16'hfff0;
  localparam gpio_t PU_VAL         = 16'h1234;
  localparam gpio_t PD_VAL         = 16'h5600;
  localparam gpio_t XTAL_PADS      = 16'h00e0;
  localparam gpio_t TRAP_PADS      = 16'h3800;

  typedef enum logic {OP_WR, OP_RD} op_e;

  typedef struct packed {
    op_e        op;
    word_t      addr;
    logic [3:0] strb;
    word_t      wdata;
    word_t      exp;
    word_t      mask;
  } step_t;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   mem_valid_i;
  word_t                  mem_addr_i;
  word_t                  mem_wdata_i;
  logic [3:0]             mem_wstrb_i;
  word_t                  ram_rdata_i = '0;
  gpio_t                  gpio_in_i;
  logic                   xtal_in_i;
  logic                   clk_pll_i;
  logic                   trap_i;
  logic                   irq_pin_i;
  logic                   irq_spi_i;
  logic [`SOC_CFG_W-1:0]  spi_cfg_i;
  logic [`SOC_MFGR_W-1:0] mfgr_id_i;
  logic [`SOC_PROD_W-1:0] prod_id_i;
  logic [`SOC_MASK_W-1:0] mask_rev_i;
  logic                   clk_ext_sel_i;
  logic                   mem_ready_o;
  word_t                  mem_rdata_o;
  logic [3:0]             ram_wstrb_o;
  logic [`SOC_RAM_AW-1:0] ram_addr_o;
  word_t                  ram_wdata_o;
  gpio_t                  gpio_out_o;
  gpio_t                  gpio_outenb_o;
  gpio_t                  gpio_pullupb_o;
  gpio_t                  gpio_pulldownb_o;
  word_t                  irq_o;

  word_t ram_mem [64];
  word_t ram_init [64];
  step_t steps [$];
  int    errors = 0;
  int    timeouts = 0;

  soc_bus_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // small synchronous sram loaded while reset is low
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 64; i++) begin
        ram_mem[i] <= ram_init[i];
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (ram_wstrb_o[b]) begin
          ram_mem[ram_addr_o[5:0]][8*b +: 8] <= ram_wdata_o[8*b +: 8];
        end
      end
    end
    ram_rdata_i <= ram_mem[ram_addr_o[5:0]];
  end

  function automatic word_t mmio_addr(logic [7:0] ofs);
    return {`SOC_MMIO_PAGE, ofs};
  endfunction

  function automatic void push_write(word_t addr, logic [3:0] strb, word_t wdata);
    steps.push_back(step_t'{OP_WR, addr, strb, wdata, 32'h0, 32'h0});
  endfunction

  function automatic void push_read(word_t addr, word_t exp, word_t mask = '1);
    steps.push_back(step_t'{OP_RD, addr, 4'h0, 32'h0, exp, mask});
  endfunction

  task automatic check_value(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("Error: %0d ns: %s: got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic bus_access(input word_t addr, input logic [3:0] strb, input word_t wdata,
                            output word_t rdata);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    @(posedge clk_i);
    mem_valid_i <= 1'b1;
    mem_addr_i  <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= strb;
    while (!seen && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      if (mem_ready_o) begin
        seen  = 1'b1;
        rdata = mem_rdata_o;
      end else begin
        waited++;
      end
    end
    if (!seen) begin
      $display("Timeout: no ready from the bus for address %h after %0d cycles", addr, waited);
      timeouts++;
    end else begin
      // exactly one idle cycle between valid and ready
      check_value(word_t'(waited), 32'd1, $sformatf("ready latency at %h", addr));
    end
    @(posedge clk_i);
    mem_valid_i <= 1'b0;
    mem_wstrb_i <= 4'h0;
  endtask

  task automatic run_steps();
    step_t s;
    word_t rdata;
    while (steps.size() > 0) begin
      s = steps.pop_front();
      if (s.op == OP_WR) begin
        bus_access(s.addr, s.strb, s.wdata, rdata);
      end else begin
        bus_access(s.addr, 4'h0, s.wdata, rdata);
        check_value(rdata & s.mask, s.exp & s.mask, $sformatf("read of %h", s.addr));
      end
    end
  endtask

  task automatic check_pads(input gpio_t out, input gpio_t oeb, input gpio_t pu,
                            input gpio_t pd, input string what);
    @(negedge clk_i);
    check_value(word_t'(gpio_out_o), word_t'(out), {what, ": gpio_out_o"});
    check_value(word_t'(gpio_outenb_o), word_t'(oeb), {what, ": gpio_outenb_o"});
    check_value(word_t'(gpio_pullupb_o), word_t'(pu), {what, ": gpio_pullupb_o"});
    check_value(word_t'(gpio_pulldownb_o), word_t'(pd), {what, ": gpio_pulldownb_o"});
  endtask

  initial begin
    gpio_t       gin;
    int unsigned r;
    word_t       exp_irq;
    gpio_t       exp_out;

    void'($urandom(SEED));
    for (int i = 0; i < 64; i++) begin
      ram_init[i] = $urandom();
    end
    rst_n_i       <= 1'b0;
    mem_valid_i   <= 1'b0;
    mem_addr_i    <= '0;
    mem_wdata_i   <= '0;
    mem_wstrb_i   <= 4'h0;
    gpio_in_i     <= gpio_t'($urandom());
    xtal_in_i     <= 1'b0;
    clk_pll_i     <= 1'b0;
    trap_i        <= 1'b0;
    irq_pin_i     <= 1'b0;
    irq_spi_i     <= 1'b0;
    spi_cfg_i     <= 8'h5a;
    mfgr_id_i     <= 12'h456;
    prod_id_i     <= 8'h21;
    mask_rev_i    <= 4'h3;
    clk_ext_sel_i <= 1'b1;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_value(word_t'(gpio_outenb_o), 32'h0000_ffff, "gpio_outenb_o in reset");
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    check_pads(16'h0000, 16'hffff, 16'h0000, 16'h0000, "after reset");
    check_value(irq_o, 32'h0, "irq_o after reset");

    // sram byte merging
    push_write(32'h0000_0010, 4'b1111, 32'h1122_3344);
    push_write(32'h0000_0010, 4'b0101, 32'haabb_ccdd);
    push_read(32'h0000_0010, 32'h11bb_33dd);
    push_write(32'h0000_0024, 4'b1111, 32'h0bad_f00d);
    push_write(32'h0000_0024, 4'b1000, 32'hc000_0000);
    push_write(32'h0000_0024, 4'b0010, 32'h0000_1200);
    push_read(32'h0000_0024, 32'hc0ad_120d);
    push_write(32'h0000_fffc, 4'b1111, 32'hdead_beef);
    push_read(32'h0000_fffc, 32'hdead_beef);
    push_read(32'h0000_0080, ram_init[32]);
    // gpio registers
    push_read(mmio_addr(`SOC_REG_OEB), 32'h0000_ffff);
    push_read(mmio_addr(`SOC_REG_GPIO), {16'h0000, gpio_in_i});
    push_write(mmio_addr(`SOC_REG_GPIO), 4'b0001, 32'h0000_00a5);
    push_write(mmio_addr(`SOC_REG_GPIO), 4'b0010, 32'h0000_3c00);
    push_write(mmio_addr(`SOC_REG_GPIO), 4'b1100, 32'hffff_0000);
    push_read(mmio_addr(`SOC_REG_GPIO), {GPIO_VAL, gpio_in_i});
    push_write(mmio_addr(`SOC_REG_OEB), 4'b0001, 32'h0000_00f0);
    push_read(mmio_addr(`SOC_REG_OEB), {16'h0000, OEB_VAL});
    push_write(mmio_addr(`SOC_REG_PU), 4'b0011, 32'h0000_1234);
    push_read(mmio_addr(`SOC_REG_PU), {16'h0000, PU_VAL});
    push_write(mmio_addr(`SOC_REG_PD), 4'b0010, 32'h0000_56ff);
    push_read(mmio_addr(`SOC_REG_PD), {16'h0000, PD_VAL});
    // configuration words and holes in the page
    push_read(mmio_addr(`SOC_REG_CFG), 32'h0000_005a);
    push_read(mmio_addr(`SOC_REG_MFGR), 32'h0000_0456);
    push_read(mmio_addr(`SOC_REG_PROD), 32'h0000_0021);
    push_read(mmio_addr(`SOC_REG_MASK), 32'h0000_0003);
    push_read(mmio_addr(`SOC_REG_CLKSEL), 32'h0000_0001);
    push_read(mmio_addr(8'h10), 32'h0);
    push_read(mmio_addr(8'h1c), 32'h0);
    push_read(mmio_addr(8'h20), 32'h0);
    push_read(mmio_addr(8'hfc), 32'h0);
    run_steps();
    check_pads(GPIO_VAL, OEB_VAL, PU_VAL, PD_VAL, "registers on pads");

    // crystal onto pad 6
    push_write(mmio_addr(`SOC_REG_XTAL_DEST), 4'b0001, 32'd2);
    push_read(mmio_addr(`SOC_REG_XTAL_DEST), 32'd2);
    run_steps();
    exp_out = GPIO_VAL;
    for (int v = 0; v < 2; v++) begin
      @(posedge clk_i);
      xtal_in_i  <= v[0];
      exp_out[6] = v[0];
      check_pads(exp_out, OEB_VAL & ~XTAL_PADS, PU_VAL | XTAL_PADS, PD_VAL | XTAL_PADS,
                 $sformatf("xtal_in_i %0d on pad 6", v));
    end

    // trap onto pad 11 where register bit 11 is set
    push_write(mmio_addr(`SOC_REG_XTAL_DEST), 4'b0001, 32'd0);
    push_write(mmio_addr(`SOC_REG_TRAP_DEST), 4'b0001, 32'd1);
    push_read(mmio_addr(`SOC_REG_TRAP_DEST), 32'd1);
    run_steps();
    exp_out = GPIO_VAL;
    for (int v = 1; v >= 0; v--) begin
      @(posedge clk_i);
      trap_i      <= v[0];
      exp_out[11] = v[0];
      check_pads(exp_out, OEB_VAL & ~TRAP_PADS, PU_VAL | TRAP_PADS, PD_VAL | TRAP_PADS,
                 $sformatf("trap_i %0d on pad 11", v));
    end
    push_write(mmio_addr(`SOC_REG_TRAP_DEST), 4'b0001, 32'd0);
    run_steps();
    check_pads(GPIO_VAL, OEB_VAL, PU_VAL, PD_VAL, "routing off");

    // interrupt lines 7 and 8 from gpio inputs
    push_write(mmio_addr(`SOC_REG_IRQ7_SRC), 4'b0001, 32'd3);
    push_write(mmio_addr(`SOC_REG_IRQ8_SRC), 4'b0001, 32'd1);
    push_read(mmio_addr(`SOC_REG_IRQ7_SRC), 32'd3);
    push_read(mmio_addr(`SOC_REG_IRQ8_SRC), 32'd1);
    run_steps();
    for (int n = 0; n < 8; n++) begin
      gin = gpio_t'($urandom());
      r   = $urandom();
      @(posedge clk_i);
      gpio_in_i <= gin;
      irq_pin_i <= r[0];
      irq_spi_i <= r[1];
      exp_irq = '0;
      exp_irq[`SOC_IRQ_PIN]  = r[0];
      exp_irq[`SOC_IRQ_SPI]  = r[1];
      exp_irq[`SOC_IRQ_SEL7] = gin[2];
      exp_irq[`SOC_IRQ_SEL8] = gin[3];
      @(negedge clk_i);
      check_value(irq_o, exp_irq, $sformatf("irq_o for gpio_in_i %h", gin));
    end

    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/bus_router.sv
rtl/mmio_regs.sv
rtl/gpio_pad_ctrl.sv
rtl/irq_vector.sv
rtl/soc_bus_top.sv
tb/soc_bus_properties.sv
tb/soc_bus_tb.sv
